//--- src/id_pkg.sv
package id_pkg;

   ////////////////////
   // Widths
   ////////////////////
   localparam int REG_W      = 32;
   localparam int REG_ADDR_W = 5;
   localparam int REG_COUNT  = 32;
   localparam int RA_ADDR    = 31;
   localparam int OPCODE_W   = 6;
   localparam int FUNCT_W    = 6;
   localparam int IMM_W      = 16;
   localparam int SHAMT_W    = 5;
   localparam int JTARGET_W  = 26;
   localparam int ALUOP_W    = 4;
   localparam int DSIZE_W    = 2;

   // EX   {alu code, imm select, unsigned, use shamt}
   // MEM  {read en, write en, unsigned, data size}
   // WB   {dest reg, reg write en, mem/alu select, data/pc select}
   localparam int EX_W  = ALUOP_W + 3;
   localparam int MEM_W = DSIZE_W + 3;
   localparam int WB_W  = REG_ADDR_W + 3;

   ////////////////////
   // Opcodes
   ////////////////////
   localparam logic [OPCODE_W-1:0] OP_R    = 6'b000000;
   localparam logic [OPCODE_W-1:0] OP_LB   = 6'b100000;
   localparam logic [OPCODE_W-1:0] OP_LH   = 6'b100001;
   localparam logic [OPCODE_W-1:0] OP_LW   = 6'b100011;
   localparam logic [OPCODE_W-1:0] OP_LBU  = 6'b100100;
   localparam logic [OPCODE_W-1:0] OP_LHU  = 6'b100101;
   localparam logic [OPCODE_W-1:0] OP_SB   = 6'b101000;
   localparam logic [OPCODE_W-1:0] OP_SH   = 6'b101001;
   localparam logic [OPCODE_W-1:0] OP_SW   = 6'b101011;
   localparam logic [OPCODE_W-1:0] OP_ADDI = 6'b001001;
   localparam logic [OPCODE_W-1:0] OP_ANDI = 6'b001100;
   localparam logic [OPCODE_W-1:0] OP_ORI  = 6'b001101;
   localparam logic [OPCODE_W-1:0] OP_XORI = 6'b001110;
   localparam logic [OPCODE_W-1:0] OP_LUI  = 6'b001111;
   localparam logic [OPCODE_W-1:0] OP_SLTI = 6'b001010;
   localparam logic [OPCODE_W-1:0] OP_BEQ  = 6'b000100;
   localparam logic [OPCODE_W-1:0] OP_BNE  = 6'b000101;
   localparam logic [OPCODE_W-1:0] OP_J    = 6'b000010;
   localparam logic [OPCODE_W-1:0] OP_JAL  = 6'b000011;

   // R-type function field
   localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
   localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
   localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
   localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
   localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
   localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
   localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
   localparam logic [FUNCT_W-1:0] FN_JALR = 6'b001001;
   localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
   localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
   localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
   localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
   localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
   localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
   localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;

   ////////////////////
   // ALU codes
   ////////////////////
   localparam logic [ALUOP_W-1:0] ALU_ADD = 4'b0000;
   localparam logic [ALUOP_W-1:0] ALU_SUB = 4'b0001;
   localparam logic [ALUOP_W-1:0] ALU_AND = 4'b0010;
   localparam logic [ALUOP_W-1:0] ALU_OR  = 4'b0011;
   localparam logic [ALUOP_W-1:0] ALU_XOR = 4'b0100;
   localparam logic [ALUOP_W-1:0] ALU_NOR = 4'b0101;
   localparam logic [ALUOP_W-1:0] ALU_SRL = 4'b0110;
   localparam logic [ALUOP_W-1:0] ALU_SLL = 4'b0111;
   localparam logic [ALUOP_W-1:0] ALU_SRA = 4'b1000;
   localparam logic [ALUOP_W-1:0] ALU_SLT = 4'b1010;
   localparam logic [ALUOP_W-1:0] ALU_LUI = 4'b1011;

   // Memory access size
   localparam logic [DSIZE_W-1:0] DSIZE_BYTE = 2'b00;
   localparam logic [DSIZE_W-1:0] DSIZE_HALF = 2'b01;
   localparam logic [DSIZE_W-1:0] DSIZE_WORD = 2'b10;

   ////////////////////
   // Instruction word
   ////////////////////
   typedef struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [SHAMT_W-1:0]    shamt;
      logic [FUNCT_W-1:0]    funct;
   } instr_r_t;

   typedef struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [IMM_W-1:0]      imm;
   } instr_i_t;

   typedef struct packed {
      logic [OPCODE_W-1:0]  opcode;
      logic [JTARGET_W-1:0] target;
   } instr_j_t;

   typedef union packed {
      instr_r_t r;
      instr_i_t i;
      instr_j_t j;
   } instr_u;

endpackage

//--- src/rf_read_if.sv
`timescale 1ns/100ps

interface rf_read_if;
   import id_pkg::*;

   logic [REG_ADDR_W-1:0] rs_addr;
   logic [REG_ADDR_W-1:0] rt_addr;
   logic [REG_W-1:0]      rs_data;
   logic [REG_W-1:0]      rt_data;

   modport ctrl (output rs_addr, rt_addr);
   modport rf   (input rs_addr, rt_addr, output rs_data, rt_data);
   modport sink (input rs_data, rt_data);

endinterface

//--- src/id_ctrl_if.sv
`timescale 1ns/100ps

interface id_ctrl_if;

   // Flow decisions, valid in the decode cycle
   logic is_branch;
   logic branch_ne;
   logic jump_rs;
   logic jump_inm;

   modport ctrl (output is_branch, branch_ne, jump_rs, jump_inm);
   modport br   (input is_branch, branch_ne, jump_rs, jump_inm);

endinterface

//--- src/id_control.sv
`timescale 1ns/100ps

module id_control (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  id_pkg::instr_u           i_instruction,
   rf_read_if.ctrl                  rd,
   id_ctrl_if.ctrl                  dec,
   output logic [id_pkg::EX_W-1:0]  o_ex_ctrl,
   output logic [id_pkg::MEM_W-1:0] o_mem_ctrl,
   output logic [id_pkg::WB_W-1:0]  o_wb_ctrl,
   output logic                     o_rinst,
   output logic                     o_store
);
   import id_pkg::*;

   logic                  r_type, to_ra, use_imm, use_shamt;
   logic                  is_branch, branch_ne, jump_rs, jump_inm;
   logic                  ex_unsigned, mem_unsigned;
   logic                  rd_en, wr_en;
   logic                  reg_we, mem_alu, data_pc;
   logic [ALUOP_W-1:0]    alu_op;
   logic [DSIZE_W-1:0]    dsize;
   logic [REG_ADDR_W-1:0] dest;

   assign rd.rs_addr = i_instruction.r.rs;
   assign rd.rt_addr = i_instruction.r.rt;

   ////////////////////
   // Decode
   ////////////////////
   always_comb begin
      r_type       = 1'b0;
      to_ra        = 1'b0;
      use_imm      = 1'b0;
      use_shamt    = 1'b0;
      is_branch    = 1'b0;
      branch_ne    = 1'b0;
      jump_rs      = 1'b0;
      jump_inm     = 1'b0;
      ex_unsigned  = 1'b0;
      mem_unsigned = 1'b0;
      rd_en        = 1'b0;
      wr_en        = 1'b0;
      reg_we       = 1'b0;
      mem_alu      = 1'b0;
      data_pc      = 1'b0;
      alu_op       = ALU_ADD;
      dsize        = DSIZE_BYTE;

      case (i_instruction.r.opcode)
         OP_R: begin
            r_type  = 1'b1;
            reg_we  = 1'b1;
            mem_alu = 1'b1;
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
            use_imm = 1'b1;
            rd_en   = 1'b1;
            reg_we  = 1'b1;
         end
         OP_SB, OP_SH, OP_SW: begin
            use_imm = 1'b1;
            wr_en   = 1'b1;
         end
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
            mem_alu = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            use_imm   = 1'b1;
            is_branch = 1'b1;
            branch_ne = (i_instruction.r.opcode == OP_BNE);
         end
         OP_J: jump_inm = 1'b1;
         OP_JAL: begin
            jump_inm = 1'b1;
            to_ra    = 1'b1;
            reg_we   = 1'b1;
            data_pc  = 1'b1;
         end
         default: ;
      endcase

      // Size and sign of memory accesses
      case (i_instruction.r.opcode)
         OP_LH, OP_LHU, OP_SH: dsize = DSIZE_HALF;
         OP_LW, OP_SW:         dsize = DSIZE_WORD;
         default:              dsize = DSIZE_BYTE;
      endcase
      mem_unsigned = (i_instruction.r.opcode == OP_LBU) || (i_instruction.r.opcode == OP_LHU);

      // Logical immediates are zero extended
      case (i_instruction.r.opcode)
         OP_ANDI: begin alu_op = ALU_AND; ex_unsigned = 1'b1; end
         OP_ORI:  begin alu_op = ALU_OR;  ex_unsigned = 1'b1; end
         OP_XORI: begin alu_op = ALU_XOR; ex_unsigned = 1'b1; end
         OP_LUI:  begin alu_op = ALU_LUI; ex_unsigned = 1'b1; end
         OP_SLTI: alu_op = ALU_SLT;
         default: ;
      endcase

      if (r_type) begin
         case (i_instruction.r.funct)
            FN_SLL:  begin alu_op = ALU_SLL; use_shamt = 1'b1; end
            FN_SRL:  begin alu_op = ALU_SRL; use_shamt = 1'b1; end
            FN_SRA:  begin alu_op = ALU_SRA; use_shamt = 1'b1; end
            FN_SLLV: alu_op = ALU_SLL;
            FN_SRLV: alu_op = ALU_SRL;
            FN_SRAV: alu_op = ALU_SRA;
            FN_ADDU: alu_op = ALU_ADD;
            FN_SUBU: alu_op = ALU_SUB;
            FN_AND:  alu_op = ALU_AND;
            FN_OR:   alu_op = ALU_OR;
            FN_XOR:  alu_op = ALU_XOR;
            FN_NOR:  alu_op = ALU_NOR;
            FN_SLT:  alu_op = ALU_SLT;
            FN_JR:   jump_rs = 1'b1;
            FN_JALR: begin jump_rs = 1'b1; data_pc = 1'b1; end
            default: ;
         endcase
      end
   end

   // Link register for JAL, rt for immediate forms
   assign dest = to_ra   ? REG_ADDR_W'(RA_ADDR) :
                 use_imm ? i_instruction.i.rt   : i_instruction.r.rd;

   assign dec.is_branch = is_branch;
   assign dec.branch_ne = branch_ne;
   assign dec.jump_rs   = jump_rs;
   assign dec.jump_inm  = jump_inm;

   assign o_rinst = r_type;
   assign o_store = wr_en;

   ////////////////////
   // Control frames
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
      end else begin
         o_ex_ctrl  <= {alu_op, use_imm, ex_unsigned, use_shamt};
         o_mem_ctrl <= {rd_en, wr_en, mem_unsigned, dsize};
         o_wb_ctrl  <= {dest, reg_we && (dest != '0), mem_alu, data_pc};
      end
   end

endmodule

//--- src/regfile.sv
`timescale 1ns/100ps

module regfile (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic [id_pkg::REG_ADDR_W-1:0] i_wr_addr,
   input  logic [id_pkg::REG_W-1:0]      i_wr_data,
   input  logic                          i_wr_en,
   rf_read_if.rf                         rd
);
   import id_pkg::*;

   logic [REG_W-1:0] regs [REG_COUNT];

   // Whole file clears on reset
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // Reads see the old value in the write cycle
   assign rd.rs_data = regs[rd.rs_addr];
   assign rd.rt_data = regs[rd.rt_addr];

endmodule

//--- src/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
   input  logic                     i_clk,
   input  logic                     i_rst,
   rf_read_if.sink                  rd,
   id_ctrl_if.br                    dec,
   output logic [id_pkg::REG_W-1:0] o_jump_rs_addr,
   output logic                     o_nop
);
   import id_pkg::*;

   logic operands_eq;
   logic taken;

   assign operands_eq = (rd.rs_data == rd.rt_data);

   // BNE inverts the compare
   assign taken = dec.is_branch && (dec.branch_ne ^ operands_eq);

   // Flush the fetched slot on any change of flow
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_nop <= 1'b0;
      end else begin
         o_nop <= dec.jump_rs || dec.jump_inm || taken;
      end
   end

   assign o_jump_rs_addr = REG_W'(rd.rs_data);

endmodule

//--- src/id_ex_operands.sv
`timescale 1ns/100ps

module id_ex_operands (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  id_pkg::instr_u             i_instruction,
   input  logic [id_pkg::REG_W-1:0]   i_pc,
   rf_read_if.sink                    rd,
   output logic [id_pkg::REG_W-1:0]   o_a,
   output logic [id_pkg::REG_W-1:0]   o_b,
   output logic [id_pkg::IMM_W-1:0]   o_inm,
   output logic [id_pkg::SHAMT_W-1:0] o_shamt,
   output logic [id_pkg::REG_W-1:0]   o_pc
);
   import id_pkg::*;

   ////////////////////
   // Operands and PC
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_a  <= '0;
         o_b  <= '0;
         o_pc <= '0;
      end else begin
         o_a  <= rd.rs_data;
         o_b  <= rd.rt_data;
         o_pc <= i_pc;
      end
   end

   // Instruction fields
   always_ff @(posedge i_clk) begin
      o_inm   <= IMM_W'(i_instruction.i.imm);
      o_shamt <= SHAMT_W'(i_instruction.r.shamt);
   end

endmodule

//--- src/id_stage.sv
`timescale 1ns/100ps

module id_stage (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic [id_pkg::REG_W-1:0]       i_instruction,
   input  logic [id_pkg::REG_W-1:0]       i_pc,
   input  logic [id_pkg::REG_ADDR_W-1:0]  i_regfile_addr,
   input  logic [id_pkg::REG_W-1:0]       i_regfile_data,
   input  logic                           i_regfile_we,
   output logic [id_pkg::EX_W-1:0]        o_ex_ctrl,
   output logic [id_pkg::MEM_W-1:0]       o_mem_ctrl,
   output logic [id_pkg::WB_W-1:0]        o_wb_ctrl,
   output logic [id_pkg::REG_W-1:0]       o_pc,
   output logic [id_pkg::REG_W-1:0]       o_a,
   output logic [id_pkg::REG_W-1:0]       o_b,
   output logic [id_pkg::IMM_W-1:0]       o_inm,
   output logic [id_pkg::SHAMT_W-1:0]     o_shamt,
   output logic                           o_nop,
   output logic                           o_branch,
   output logic                           o_jump_rs,
   output logic [id_pkg::REG_W-1:0]       o_jump_rs_addr,
   output logic                           o_jump_inm,
   output logic [id_pkg::JTARGET_W-1:0]   o_jump_inm_addr,
   output logic                           o_rinst,
   output logic                           o_store
);
   import id_pkg::*;

   rf_read_if rf_bus ();
   id_ctrl_if dec_bus ();

   id_control u_control (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (i_instruction),
      .rd            (rf_bus.ctrl),
      .dec           (dec_bus.ctrl),
      .o_ex_ctrl     (o_ex_ctrl),
      .o_mem_ctrl    (o_mem_ctrl),
      .o_wb_ctrl     (o_wb_ctrl),
      .o_rinst       (o_rinst),
      .o_store       (o_store)
   );

   regfile u_regfile (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_wr_addr (i_regfile_addr),
      .i_wr_data (i_regfile_data),
      .i_wr_en   (i_regfile_we),
      .rd        (rf_bus.rf)
   );

   branch_unit u_branch (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .rd             (rf_bus.sink),
      .dec            (dec_bus.br),
      .o_jump_rs_addr (o_jump_rs_addr),
      .o_nop          (o_nop)
   );

   id_ex_operands u_operands (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (i_instruction),
      .i_pc          (i_pc),
      .rd            (rf_bus.sink),
      .o_a           (o_a),
      .o_b           (o_b),
      .o_inm         (o_inm),
      .o_shamt       (o_shamt),
      .o_pc          (o_pc)
   );

   // Same-cycle flow flags
   assign o_branch        = dec_bus.is_branch;
   assign o_jump_rs       = dec_bus.jump_rs;
   assign o_jump_inm      = dec_bus.jump_inm;
   assign o_jump_inm_addr = i_instruction[JTARGET_W-1:0];

endmodule

//--- sim/id_stage_chk.sv
`timescale 1ns/100ps

module id_stage_chk (
   input logic                     i_clk,
   input logic                     i_rst,
   input logic                     i_branch,
   input logic                     i_jump_rs,
   input logic                     i_jump_inm,
   input logic                     i_nop,
   input logic                     i_store,
   input logic [id_pkg::EX_W-1:0]  i_ex_ctrl,
   input logic [id_pkg::MEM_W-1:0] i_mem_ctrl,
   input logic [id_pkg::WB_W-1:0]  i_wb_ctrl
);
   import id_pkg::*;

   logic                  flow_change;
   logic                  wb_we;
   logic                  mem_we;
   logic [REG_ADDR_W-1:0] wb_dest;

   assign flow_change = i_branch || i_jump_rs || i_jump_inm;
   assign wb_dest     = i_wb_ctrl[WB_W-1 -: REG_ADDR_W];
   assign wb_we       = i_wb_ctrl[2];
   assign mem_we      = i_mem_ctrl[MEM_W-2];

   // Jumps always flush the next slot
   nop_on_jump: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_jump_rs || i_jump_inm) |=> i_nop)
      else $error("o_nop not set after a jump");

   // No flush without a branch or jump
   nop_needs_flow: assert property (@(posedge i_clk) disable iff (i_rst)
      !flow_change |=> !i_nop)
      else $error("o_nop set without a branch or jump");

   wb_not_zero: assert property (@(posedge i_clk) disable iff (i_rst)
      !(wb_we && wb_dest == '0))
      else $error("register write enabled for destination zero");

   store_frame: assert property (@(posedge i_clk) disable iff (i_rst)
      1'b1 |=> (mem_we == $past(i_store)))
      else $error("MEM write enable does not follow o_store");

   reset_clears: assert property (@(posedge i_clk)
      i_rst |=> (i_ex_ctrl == '0 && i_mem_ctrl == '0 && i_wb_ctrl == '0 && !i_nop))
      else $error("control frames not zero after reset");

endmodule

//--- sim/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage;
   import id_pkg::*;

   localparam logic [31:0] SEED = 32'h0d06_4e1d;

   localparam logic [5:0] R_FUNCS [13] = '{
      FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU,
      FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT
   };
   localparam logic [5:0] I_OPS [14] = '{
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW,
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI
   };

   logic                  i_clk;
   logic                  i_rst;
   logic [REG_W-1:0]      i_instruction;
   logic [REG_W-1:0]      i_pc;
   logic [REG_ADDR_W-1:0] i_regfile_addr;
   logic [REG_W-1:0]      i_regfile_data;
   logic                  i_regfile_we;
   logic [EX_W-1:0]       o_ex_ctrl;
   logic [MEM_W-1:0]      o_mem_ctrl;
   logic [WB_W-1:0]       o_wb_ctrl;
   logic [REG_W-1:0]      o_pc;
   logic [REG_W-1:0]      o_a;
   logic [REG_W-1:0]      o_b;
   logic [IMM_W-1:0]      o_inm;
   logic [SHAMT_W-1:0]    o_shamt;
   logic                  o_nop;
   logic                  o_branch;
   logic                  o_jump_rs;
   logic [REG_W-1:0]      o_jump_rs_addr;
   logic                  o_jump_inm;
   logic [JTARGET_W-1:0]  o_jump_inm_addr;
   logic                  o_rinst;
   logic                  o_store;

   logic [REG_W-1:0] shadow [REG_COUNT];
   int tests = 0;
   int errors = 0;
   int test_errors = 0;

   id_stage u_dut (.*);

   bind id_stage id_stage_chk u_chk (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_branch   (o_branch),
      .i_jump_rs  (o_jump_rs),
      .i_jump_inm (o_jump_inm),
      .i_nop      (o_nop),
      .i_store    (o_store),
      .i_ex_ctrl  (o_ex_ctrl),
      .i_mem_ctrl (o_mem_ctrl),
      .i_wb_ctrl  (o_wb_ctrl)
   );

   initial begin
      i_clk = 1'b0;
      forever begin
         #4 i_clk = ~i_clk;
      end
   end

   initial begin
      #500000;
      $display("Run did not finish within the time limit");
      $display("SIMULATION FAILED");
      $finish;
   end

   ////////////////////
   // Helpers
   ////////////////////
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error %s: got %h, expected %h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      errors += test_errors;
      $display("test %-8s done, %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   // Sample point for registered outputs
   task automatic next_edge();
      @(posedge i_clk);
      #1;
   endtask

   task automatic drive_instr(input logic [31:0] instr, input logic [31:0] pc);
      @(posedge i_clk);
      #1;
      i_instruction = instr;
      i_pc = pc;
      #2;
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      @(posedge i_clk);
      #1;
      i_regfile_we = 1'b1;
      i_regfile_addr = addr;
      i_regfile_data = data;
      @(posedge i_clk);
      #1;
      i_regfile_we = 1'b0;
      shadow[addr] = data;
   endtask

   function automatic logic [3:0] r_alu(input logic [5:0] fn);
      case (fn)
         FN_SLL, FN_SLLV: return ALU_SLL;
         FN_SRL, FN_SRLV: return ALU_SRL;
         FN_SRA, FN_SRAV: return ALU_SRA;
         FN_SUBU:         return ALU_SUB;
         FN_AND:          return ALU_AND;
         FN_OR:           return ALU_OR;
         FN_XOR:          return ALU_XOR;
         FN_NOR:          return ALU_NOR;
         FN_SLT:          return ALU_SLT;
         default:         return ALU_ADD;
      endcase
   endfunction

   // {alu, ex unsigned, rd en, wr en, mem unsigned, size, reg we, alu result}
   function automatic logic [11:0] imm_expect(input logic [5:0] op);
      case (op)
         OP_LB:   return {ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b0};
         OP_LH:   return {ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0, DSIZE_HALF, 1'b1, 1'b0};
         OP_LW:   return {ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0, DSIZE_WORD, 1'b1, 1'b0};
         OP_LBU:  return {ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b1, DSIZE_BYTE, 1'b1, 1'b0};
         OP_LHU:  return {ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b1, DSIZE_HALF, 1'b1, 1'b0};
         OP_SB:   return {ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, DSIZE_BYTE, 1'b0, 1'b0};
         OP_SH:   return {ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, DSIZE_HALF, 1'b0, 1'b0};
         OP_SW:   return {ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, DSIZE_WORD, 1'b0, 1'b0};
         OP_ADDI: return {ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b1};
         OP_SLTI: return {ALU_SLT, 1'b0, 1'b0, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b1};
         OP_ANDI: return {ALU_AND, 1'b1, 1'b0, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b1};
         OP_ORI:  return {ALU_OR,  1'b1, 1'b0, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b1};
         OP_XORI: return {ALU_XOR, 1'b1, 1'b0, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b1};
         OP_LUI:  return {ALU_LUI, 1'b1, 1'b0, 1'b0, 1'b0, DSIZE_BYTE, 1'b1, 1'b1};
         default: return '0;
      endcase
   endfunction

   ////////////////////
   // Tests
   ////////////////////
   task automatic reset_state();
      check_value("o_ex_ctrl", 32'(o_ex_ctrl), 32'h0);
      check_value("o_mem_ctrl", 32'(o_mem_ctrl), 32'h0);
      check_value("o_wb_ctrl", 32'(o_wb_ctrl), 32'h0);
      check_value("o_nop", 32'(o_nop), 32'h0);
      check_value("o_a", o_a, 32'h0);
      check_value("o_b", o_b, 32'h0);
      check_value("o_pc", o_pc, 32'h0);
      for (int r = 0; r < REG_COUNT; r++) begin
         drive_instr({OP_R, 5'(r), 5'(r), 5'd0, 5'd0, FN_ADDU}, 32'h0);
         check_value("o_jump_rs_addr", o_jump_rs_addr, 32'h0);
         next_edge();
         check_value("o_a", o_a, 32'h0);
         check_value("o_b", o_b, 32'h0);
      end
   endtask

   task automatic regfile_readback();
      logic [4:0]  addrs [8];
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [31:0] pc;
      for (int k = 0; k < 8; k++) begin
         addrs[k] = 5'($urandom_range(31, 1));
         write_reg(addrs[k], $urandom);
      end
      for (int k = 0; k < 8; k++) begin
         rs = addrs[$urandom_range(7, 0)];
         rt = addrs[$urandom_range(7, 0)];
         pc = $urandom & 32'hffff_fffc;
         drive_instr({OP_R, rs, rt, 5'd0, 5'd0, FN_ADDU}, pc);
         next_edge();
         check_value("o_a", o_a, shadow[rs]);
         check_value("o_b", o_b, shadow[rt]);
         check_value("o_pc", o_pc, pc);
      end
   endtask

   task automatic rtype_decode();
      logic [5:0] fn;
      logic [4:0] rd;
      logic [4:0] sh;
      logic       shifts;
      for (int k = 0; k < 13; k++) begin
         fn = R_FUNCS[k];
         rd = (k == 0) ? 5'd0 : 5'($urandom);
         sh = 5'($urandom);
         shifts = (fn == FN_SLL) || (fn == FN_SRL) || (fn == FN_SRA);
         drive_instr({OP_R, 5'($urandom), 5'($urandom), rd, sh, fn}, 32'h0);
         check_value("o_rinst", 32'(o_rinst), 32'd1);
         next_edge();
         check_value("o_ex_ctrl", 32'(o_ex_ctrl), 32'({r_alu(fn), 1'b0, 1'b0, shifts}));
         check_value("o_mem_ctrl", 32'(o_mem_ctrl), 32'h0);
         check_value("o_wb_ctrl", 32'(o_wb_ctrl), 32'({rd, rd != 5'd0, 1'b1, 1'b0}));
         check_value("o_shamt", 32'(o_shamt), 32'(sh));
      end
   endtask

   task automatic imm_decode();
      logic [11:0] e;
      logic [4:0]  rt;
      logic [15:0] imm;
      for (int k = 0; k < 14; k++) begin
         rt = 5'($urandom_range(31, 1));
         imm = 16'($urandom);
         e = imm_expect(I_OPS[k]);
         drive_instr({I_OPS[k], 5'($urandom), rt, imm}, 32'h0);
         check_value("o_store", 32'(o_store), 32'(e[5]));
         check_value("o_rinst", 32'(o_rinst), 32'd0);
         check_value("o_branch", 32'(o_branch), 32'd0);
         next_edge();
         check_value("o_ex_ctrl", 32'(o_ex_ctrl), 32'({e[11:8], 1'b1, e[7], 1'b0}));
         check_value("o_mem_ctrl", 32'(o_mem_ctrl), 32'(e[6:2]));
         check_value("o_wb_ctrl", 32'(o_wb_ctrl), 32'({rt, e[1], e[0], 1'b0}));
         check_value("o_inm", 32'(o_inm), 32'(imm));
      end
   endtask

   task automatic branch_resolve();
      logic [5:0]  op;
      logic [31:0] v;
      logic        same;
      for (int k = 0; k < 4; k++) begin
         op = (k < 2) ? OP_BEQ : OP_BNE;
         same = (k % 2 == 0);
         v = $urandom;
         write_reg(5'd4, v);
         write_reg(5'd5, same ? v : ~v);
         drive_instr({op, 5'd4, 5'd5, 16'($urandom)}, 32'h0);
         check_value("o_branch", 32'(o_branch), 32'd1);
         next_edge();
         // BEQ taken on equal, BNE on unequal
         check_value("o_nop", 32'(o_nop), 32'((op == OP_BNE) != same));
      end
   endtask

   task automatic jump_decode();
      logic [31:0] instr;
      logic [4:0]  rd;
      for (int k = 0; k < 4; k++) begin
         rd = 5'($urandom_range(31, 1));
         case (k)
            0:       instr = {OP_J, 26'($urandom)};
            1:       instr = {OP_JAL, 26'($urandom)};
            2:       instr = {OP_R, 5'($urandom), 5'd0, 5'd0, 5'd0, FN_JR};
            default: instr = {OP_R, 5'($urandom), 5'd0, rd, 5'd0, FN_JALR};
         endcase
         drive_instr(instr, 32'h0);
         check_value("o_jump_inm", 32'(o_jump_inm), 32'(k < 2));
         check_value("o_jump_rs", 32'(o_jump_rs), 32'(k >= 2));
         check_value("o_jump_inm_addr", 32'(o_jump_inm_addr), 32'(instr[25:0]));
         check_value("o_jump_rs_addr", o_jump_rs_addr, shadow[instr[25:21]]);
         next_edge();
         check_value("o_nop", 32'(o_nop), 32'd1);
         check_value("o_wb_ctrl pc select", 32'(o_wb_ctrl[0]), 32'((k == 1) || (k == 3)));
         check_value("o_wb_ctrl write enable", 32'(o_wb_ctrl[2]),
                     32'((k == 1) || (k == 3)));
         if (k == 1) begin
            check_value("o_wb_ctrl dest", 32'(o_wb_ctrl[WB_W-1 -: REG_ADDR_W]), 32'(RA_ADDR));
         end
         if (k == 3) begin
            check_value("o_wb_ctrl dest", 32'(o_wb_ctrl[WB_W-1 -: REG_ADDR_W]), 32'(rd));
         end
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////
   initial begin
      void'($urandom(SEED));
      i_rst = 1'b1;
      i_instruction = '0;
      i_pc = '0;
      i_regfile_addr = '0;
      i_regfile_data = '0;
      i_regfile_we = 1'b0;
      for (int r = 0; r < REG_COUNT; r++) begin
         shadow[r] = '0;
      end
      repeat (4) @(posedge i_clk);
      #1;
      i_rst = 1'b0;

      reset_state();
      end_test("reset");
      regfile_readback();
      end_test("regfile");
      rtype_decode();
      end_test("rtype");
      imm_decode();
      end_test("imm");
      branch_resolve();
      end_test("branch");
      jump_decode();
      end_test("jump");

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- list.f
src/id_pkg.sv
src/rf_read_if.sv
src/id_ctrl_if.sv
src/id_control.sv
src/regfile.sv
src/branch_unit.sv
src/id_ex_operands.sv
src/id_stage.sv
sim/id_stage_chk.sv
sim/tb_id_stage.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --assert --timing
TOP   = tb_id_stage
FLIST = list.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
